// File: target_placer.f
src/game_geom_pkg.sv
src/game_rng_pkg.sv
src/candidate_gen.sv
src/hit_detector.sv
src/target_keeper.sv
src/target_placer.sv
sim/target_placer_sva.sv
sim/target_placer_tb.sv

// File: sim/target_placer_tb.sv
module target_placer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import game_geom_pkg::*;
    import game_rng_pkg::*;

    localparam xpos_t START_X = 10'd32;
    localparam ypos_t START_Y = 9'd440;
    localparam int    N_ENTRY = 11;
    localparam int    LIMIT   = 400;  // Cycles allowed per wait

    // What the player sample points at
    localparam logic [1:0] AT_TARGET = 2'd0;
    localparam logic [1:0] AT_COORD  = 2'd1;  // Fixed coordinate from the table
    localparam logic [1:0] AT_OLD    = 2'd2;  // Target before the last relocation

    typedef struct packed {
        logic [1:0] kind;
        xpos_t      x;     // Miss coordinate, or the filler sample when holding
        ypos_t      y;
        logic       hit;
        logic       hold;  // Keep target_ready low after the announcement
    } stim_t;

    stim_t stim [N_ENTRY] = '{
        '{AT_COORD,  10'd100, 9'd100, 1'b0, 1'b0},  // Inside a corner block
        '{AT_TARGET, 10'd0,   9'd0,   1'b1, 1'b0},
        '{AT_OLD,    10'd0,   9'd0,   1'b0, 1'b0},
        '{AT_COORD,  10'd700, 9'd10,  1'b0, 1'b0},  // Right of the playfield
        '{AT_TARGET, 10'd320, 9'd240, 1'b1, 1'b1},  // Filler in the centre pillar
        '{AT_TARGET, 10'd0,   9'd0,   1'b1, 1'b0},
        '{AT_TARGET, 10'd0,   9'd0,   1'b1, 1'b0},
        '{AT_TARGET, 10'd0,   9'd0,   1'b1, 1'b0},
        '{AT_OLD,    10'd0,   9'd0,   1'b0, 1'b0},
        '{AT_TARGET, 10'd600, 9'd500, 1'b1, 1'b1},  // Filler below the playfield
        '{AT_TARGET, 10'd0,   9'd0,   1'b1, 1'b0}
    };

    // Obstacle rectangles with lower bounds inside and upper bounds outside
    int rect_x1 [6] = '{64, 480, 64, 480, 288, 240};
    int rect_x2 [6] = '{160, 576, 160, 576, 352, 400};
    int rect_y1 [6] = '{64, 64, 352, 352, 192, 16};
    int rect_y2 [6] = '{128, 128, 416, 416, 288, 48};

    logic   clk;
    logic   rst;
    logic   player_valid;
    logic   player_ready;
    xpos_t  player_xpos;
    ypos_t  player_ypos;
    logic   target_valid;
    logic   target_ready;
    xpos_t  target_xpos;
    ypos_t  target_ypos;
    score_t score;

    integer seed = 60670;
    int     checks;
    int     errors;
    int     test_errs;
    int     failed;
    logic   hold_ready;
    logic   timed_out;
    xpos_t  exp_x;
    ypos_t  exp_y;
    xpos_t  old_x;
    ypos_t  old_y;
    score_t exp_score;

    target_placer #(
        .SEED   (LFSR_SEED_DEFAULT),
        .START_X(START_X),
        .START_Y(START_Y)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .player_valid (player_valid),
        .player_ready (player_ready),
        .player_xpos  (player_xpos),
        .player_ypos  (player_ypos),
        .target_valid (target_valid),
        .target_ready (target_ready),
        .target_xpos  (target_xpos),
        .target_ypos  (target_ypos),
        .score        (score)
    );

    always #50 clk = ~clk;

    // Random back-pressure on the target stream unless an entry holds it
    always @(posedge clk) begin
        if (hold_ready) begin
            target_ready <= 1'b0;
        end else begin
            target_ready <= ($random(seed) & 32'd1) != 0;
        end
    end

    function automatic logic usable(input xpos_t x, input ypos_t y);
        logic ok;
        ok = (x < FIELD_W) && (y < FIELD_H);
        for (int i = 0; i < 6; i++) begin
            if (x >= rect_x1[i] && x < rect_x2[i] && y >= rect_y1[i] && y < rect_y2[i]) begin
                ok = 1'b0;  // Lands on an obstacle
            end
        end
        return ok;
    endfunction

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_pos(input xpos_t gx, input ypos_t gy, input xpos_t ex,
                             input ypos_t ey, input string what);
        checks++;
        if (gx !== ex || gy !== ey) begin
            $display("[ERROR] %0t ns: %s is (%0d,%0d), expected (%0d,%0d)",
                     $time, what, gx, gy, ex, ey);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, LIMIT);
        timed_out = 1'b1;
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, test_errs);
            failed++;
        end
    endtask

    // Waits at negedges until the pending offer is taken, then drops player_valid
    task automatic finish_transfer();
        int n;
        n = 0;
        while (!player_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= LIMIT) begin
            note_timeout("player sample transfer");
            return;
        end
        @(posedge clk);
        player_valid <= 1'b0;
        @(negedge clk);
    endtask

    // Offers one sample and returns at the negedge after its transfer
    task automatic send_sample(input xpos_t x, input ypos_t y);
        @(posedge clk);
        player_xpos  <= x;
        player_ypos  <= y;
        player_valid <= 1'b1;
        @(negedge clk);
        finish_transfer();
    endtask

    task automatic wait_target_valid();
        int n;
        n = 0;
        while (!target_valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= LIMIT) begin
            note_timeout("target_valid after a hit");
        end
    endtask

    task automatic wait_target_accept();
        int n;
        n = 0;
        while (!(target_valid && target_ready) && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= LIMIT) begin
            note_timeout("target transfer");
            return;
        end
        @(negedge clk);  // Transfer edge lies in between
    endtask

    task automatic run_entry(input int idx);
        stim_t s;
        xpos_t sx;
        ypos_t sy;
        s = stim[idx];
        sx = s.x;
        sy = s.y;
        test_errs = 0;
        if (s.kind == AT_TARGET) begin
            sx = exp_x;
            sy = exp_y;
        end else if (s.kind == AT_OLD) begin
            sx = old_x;
            sy = old_y;
        end
        hold_ready = s.hold;
        send_sample(sx, sy);
        if (timed_out) return;
        if (!s.hit) begin
            repeat (12) begin
                @(negedge clk);
                check_flag(target_valid, 1'b0, "target_valid after a miss");
            end
            check_pos(target_xpos, target_ypos, exp_x, exp_y, "target after a miss");
            check_score(score, exp_score, "score after a miss");
        end else begin
            wait_target_valid();
            if (timed_out) return;
            exp_score = exp_score + 8'd1;
            check_score(score, exp_score, "score after a hit");
            check_flag(usable(target_xpos, target_ypos), 1'b1, "new target usable");
            check_flag((target_xpos != exp_x) || (target_ypos != exp_y), 1'b1,
                       "new target differs from old");
            old_x = exp_x;
            old_y = exp_y;
            exp_x = target_xpos;
            exp_y = target_ypos;
            if (s.hold) begin
                send_sample(s.x, s.y);  // Filler gets stuck in the detector
                if (timed_out) return;
                check_flag(player_ready, 1'b0, "player_ready with a held sample");
                @(posedge clk);
                player_valid <= 1'b1;  // Second filler waits at the input
                repeat (6) begin
                    @(negedge clk);
                    check_flag(target_valid, 1'b1, "target_valid under back-pressure");
                    check_flag(player_ready, 1'b0, "player_ready under back-pressure");
                    check_pos(target_xpos, target_ypos, exp_x, exp_y,
                              "target under back-pressure");
                end
                hold_ready = 1'b0;
            end
            wait_target_accept();
            if (timed_out) return;
            check_flag(target_valid, 1'b0, "target_valid after the transfer");
            if (s.hold) begin
                finish_transfer();  // Enters once the held filler drains
                if (timed_out) return;
            end
        end
        report_test($sformatf("Entry %0d", idx));
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        player_valid = 1'b0;
        player_xpos  = '0;
        player_ypos  = '0;
        target_ready = 1'b0;
        hold_ready   = 1'b0;
        timed_out    = 1'b0;
        checks       = 0;
        errors       = 0;
        failed       = 0;
        test_errs    = 0;
        exp_x        = START_X;
        exp_y        = START_Y;
        old_x        = START_X;
        old_y        = START_Y;
        exp_score    = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(player_ready, 1'b1, "player_ready after reset");
        check_flag(target_valid, 1'b0, "target_valid after reset");
        check_score(score, 8'd0, "score after reset");
        check_pos(target_xpos, target_ypos, START_X, START_Y, "target after reset");
        report_test("Reset state");
        for (int i = 0; i < N_ENTRY && !timed_out; i++) begin
            run_entry(i);
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 N_ENTRY + 1, failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/target_placer_sva.sv
module target_placer_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  player_valid,
    input logic                  player_ready,
    input game_geom_pkg::xpos_t  player_xpos,
    input game_geom_pkg::ypos_t  player_ypos,
    input logic                  target_valid,
    input logic                  target_ready,
    input game_geom_pkg::xpos_t  target_xpos,
    input game_geom_pkg::ypos_t  target_ypos,
    input game_geom_pkg::score_t score
);

    timeunit 1ns;
    timeprecision 1ps;

    // Player stream, the environment side must hold its offer
    player_valid_held: assert property (@(posedge clk) disable iff (rst)
        player_valid && !player_ready |=> player_valid)
        else $error("player_valid dropped before the transfer");

    player_data_held: assert property (@(posedge clk) disable iff (rst)
        player_valid && !player_ready |=> $stable(player_xpos) && $stable(player_ypos))
        else $error("player sample changed while waiting");

    // Target stream, the DUT side
    target_valid_held: assert property (@(posedge clk) disable iff (rst)
        target_valid && !target_ready |=> target_valid)
        else $error("target_valid dropped before the transfer");

    target_data_held: assert property (@(posedge clk) disable iff (rst)
        target_valid && !target_ready |=>
            $stable(target_xpos) && $stable(target_ypos) && $stable(score))
        else $error("target data changed while waiting");

    target_idle_in_reset: assert property (@(posedge clk) rst |=> !target_valid)
        else $error("target_valid high right after reset");

endmodule

bind target_placer target_placer_sva i_sva (
    .clk          (clk),
    .rst          (rst),
    .player_valid (player_valid),
    .player_ready (player_ready),
    .player_xpos  (player_xpos),
    .player_ypos  (player_ypos),
    .target_valid (target_valid),
    .target_ready (target_ready),
    .target_xpos  (target_xpos),
    .target_ypos  (target_ypos),
    .score        (score)
);

// File: src/target_placer.sv
module target_placer #(
    parameter game_rng_pkg::lfsr_t  SEED    = game_rng_pkg::LFSR_SEED_DEFAULT,
    parameter game_geom_pkg::xpos_t START_X = 10'd320,
    parameter game_geom_pkg::ypos_t START_Y = 9'd400
) (
    input  logic                  clk,
    input  logic                  rst,
    // Player samples in
    input  logic                  player_valid,
    output logic                  player_ready,
    input  game_geom_pkg::xpos_t  player_xpos,
    input  game_geom_pkg::ypos_t  player_ypos,
    // New target announcements out
    output logic                  target_valid,
    input  logic                  target_ready,
    output game_geom_pkg::xpos_t  target_xpos,
    output game_geom_pkg::ypos_t  target_ypos,
    output game_geom_pkg::score_t score
);

    import game_geom_pkg::*;

    xpos_t cand_xpos;
    ypos_t cand_ypos;
    logic  cand_ok;
    logic  res_valid;
    logic  res_hit;
    logic  res_ready;

    candidate_gen #(
        .SEED(SEED)
    ) i_candidate_gen (
        .clk       (clk),
        .rst       (rst),
        .cand_xpos (cand_xpos),
        .cand_ypos (cand_ypos),
        .cand_ok   (cand_ok)
    );

    // Target outputs double as the compare value for the detector
    hit_detector i_hit_detector (
        .clk          (clk),
        .rst          (rst),
        .player_valid (player_valid),
        .player_ready (player_ready),
        .player_xpos  (player_xpos),
        .player_ypos  (player_ypos),
        .cur_xpos     (target_xpos),
        .cur_ypos     (target_ypos),
        .res_valid    (res_valid),
        .res_hit      (res_hit),
        .res_ready    (res_ready)
    );

    target_keeper #(
        .START_X(START_X),
        .START_Y(START_Y)
    ) i_target_keeper (
        .clk          (clk),
        .rst          (rst),
        .cand_xpos    (cand_xpos),
        .cand_ypos    (cand_ypos),
        .cand_ok      (cand_ok),
        .res_valid    (res_valid),
        .res_hit      (res_hit),
        .res_ready    (res_ready),
        .cur_xpos     (target_xpos),
        .cur_ypos     (target_ypos),
        .target_valid (target_valid),
        .target_ready (target_ready),
        .score        (score)
    );

endmodule

// File: src/target_keeper.sv
module target_keeper #(
    parameter game_geom_pkg::xpos_t START_X = 10'd320,
    parameter game_geom_pkg::ypos_t START_Y = 9'd400
) (
    input  logic                  clk,
    input  logic                  rst,
    input  game_geom_pkg::xpos_t  cand_xpos,
    input  game_geom_pkg::ypos_t  cand_ypos,
    input  logic                  cand_ok,
    input  logic                  res_valid,
    input  logic                  res_hit,
    output logic                  res_ready,
    output game_geom_pkg::xpos_t  cur_xpos,
    output game_geom_pkg::ypos_t  cur_ypos,
    output logic                  target_valid,
    input  logic                  target_ready,
    output game_geom_pkg::score_t score
);

    import game_geom_pkg::*;

    xpos_t  tgt_xpos;
    ypos_t  tgt_ypos;
    score_t hits;
    logic   ann_valid;
    logic   cand_new;
    logic   cand_use;
    logic   relocate;

    // Candidate must move the target somewhere else
    assign cand_new = (cand_xpos != tgt_xpos) || (cand_ypos != tgt_ypos);
    assign cand_use = cand_ok && cand_new;

    // Nothing is consumed while an announcement is still pending
    // A miss goes at once, a hit waits for a fresh usable candidate
    assign res_ready = !ann_valid && (!res_hit || cand_use);

    assign relocate = res_valid && res_hit && res_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tgt_xpos <= START_X;
            tgt_ypos <= START_Y;
            hits     <= '0;
        end else if (relocate) begin
            tgt_xpos <= cand_xpos;
            tgt_ypos <= cand_ypos;
            hits     <= hits + 8'd1;  // Wraps at 256
        end
    end

    // One announcement per relocation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ann_valid <= 1'b0;
        end else if (relocate) begin
            ann_valid <= 1'b1;
        end else if (target_ready) begin
            ann_valid <= 1'b0;  // Accepted, or was already low
        end
    end

    // Relocate only happens with ann_valid low, so the two branches
    // above never compete for the same edge

    assign cur_xpos     = tgt_xpos;
    assign cur_ypos     = tgt_ypos;
    assign score        = hits;
    assign target_valid = ann_valid;

endmodule

// File: src/hit_detector.sv
module hit_detector (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 player_valid,
    output logic                 player_ready,
    input  game_geom_pkg::xpos_t player_xpos,
    input  game_geom_pkg::ypos_t player_ypos,
    input  game_geom_pkg::xpos_t cur_xpos,
    input  game_geom_pkg::ypos_t cur_ypos,
    output logic                 res_valid,
    output logic                 res_hit,
    input  logic                 res_ready
);

    import game_geom_pkg::*;

    logic  held_valid;
    xpos_t held_xpos;
    ypos_t held_ypos;
    logic  take;

    // Free slot, or the held result leaves on this edge
    assign player_ready = !held_valid || res_ready;
    assign take         = player_valid && player_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (player_ready) begin
            held_valid <= player_valid;  // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_xpos <= player_xpos;
            held_ypos <= player_ypos;
        end
    end

    assign res_valid = held_valid;

    // Compared against the live target, not the one seen at acceptance
    // A sample stalled behind a relocation is judged on the new target
    assign res_hit = (held_xpos == cur_xpos) && (held_ypos == cur_ypos);

endmodule

// File: src/candidate_gen.sv
module candidate_gen #(
    parameter game_rng_pkg::lfsr_t SEED = game_rng_pkg::LFSR_SEED_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    output game_geom_pkg::xpos_t cand_xpos,
    output game_geom_pkg::ypos_t cand_ypos,
    output logic                 cand_ok
);

    import game_geom_pkg::*;
    import game_rng_pkg::*;

    lfsr_t state;
    logic  feedback;
    logic  in_field;
    logic  in_terrain;

    // Fibonacci form, XOR of all tapped bits enters at the bottom
    assign feedback = ^(state & LFSR_TAPS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEED;
        end else begin
            state <= {state[14:0], feedback};  // Steps every cycle
        end
    end

    // Candidate slices overlap, Y shares the low bits with X
    assign cand_xpos = state[9:0];
    assign cand_ypos = state[8:0];

    // Upper part of both ranges falls off the playfield
    assign in_field = (cand_xpos < FIELD_W) && (cand_ypos < FIELD_H);

    always_comb begin
        in_terrain = 1'b0;
        for (int i = 0; i < TERRAIN_N; i++) begin
            if (cand_xpos >= TERRAIN_X1[i] && cand_xpos < TERRAIN_X2[i] &&
                cand_ypos >= TERRAIN_Y1[i] && cand_ypos < TERRAIN_Y2[i]) begin
                in_terrain = 1'b1;  // Inside obstacle i
            end
        end
    end

    // Rejected candidates are simply skipped, the keeper waits for the next one
    assign cand_ok = in_field && !in_terrain;

endmodule

// File: src/game_rng_pkg.sv
package game_rng_pkg;

    // State of the candidate generator
    typedef logic [15:0] lfsr_t;

    // Polynomial x^16 + x^14 + x^13 + x^11 + 1
    // Bit n of the mask taps state bit n, so x^k maps to bit k-1
    localparam lfsr_t LFSR_TAPS = 16'hB400;

    // Any nonzero value works, zero would lock the register
    localparam lfsr_t LFSR_SEED_DEFAULT = 16'hACE1;

    // Maximal length sequence, the state repeats after 65535 steps
    // so every usable position comes up again sooner or later
    // X takes state bits 9 to 0, Y takes state bits 8 to 0

endpackage

// File: src/game_geom_pkg.sv
package game_geom_pkg;

    // Screen coordinates, origin top left
    typedef logic [9:0] xpos_t;
    typedef logic [8:0] ypos_t;

    typedef logic [7:0] score_t;  // Wraps after 255 hits

    localparam int FIELD_W = 640;  // Usable X range is 0 to 639
    localparam int FIELD_H = 480;  // Usable Y range is 0 to 479

    localparam int TERRAIN_N = 6;

    // Obstacle rectangles, lower bounds inside and upper bounds outside
    // Entries 0 to 3 are the corner blocks
    // Entry 4 is the centre pillar, entry 5 the wall along the top edge
    localparam xpos_t TERRAIN_X1 [TERRAIN_N] = '{
        10'd64,  10'd480,
        10'd64,  10'd480,
        10'd288, 10'd240
    };

    localparam xpos_t TERRAIN_X2 [TERRAIN_N] = '{
        10'd160, 10'd576,
        10'd160, 10'd576,
        10'd352, 10'd400
    };

    localparam ypos_t TERRAIN_Y1 [TERRAIN_N] = '{
        9'd64,   9'd64,
        9'd352,  9'd352,
        9'd192,  9'd16
    };

    localparam ypos_t TERRAIN_Y2 [TERRAIN_N] = '{
        9'd128,  9'd128,
        9'd416,  9'd416,
        9'd288,  9'd48
    };

    // The top wall is thin on purpose, targets may sit right below it
    // at Y 48, which is outside the rectangle

endpackage
